// File: verification/trap_unit_asserts.sv
`timescale 1ns/10ps

module trap_unit_asserts
    import csr_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  cyc_i,
    input logic  stb_i,
    input logic  ack_i,
    input logic  trap_valid_i,
    input xlen_t trap_target_i
);

    int fail_count = 0;

    // ack answers a strobe seen on the previous edge
    ack_after_stb: assert property (
        @(posedge clk) disable iff (!rst_n) ack_i |-> $past(cyc_i && stb_i)
    ) else begin
        $error("timer bus ack without a strobe on the edge before");
        fail_count++;
    end

    ack_single: assert property (
        @(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i
    ) else begin
        $error("timer bus ack high on two edges in a row");
        fail_count++;
    end

    no_trap_in_reset: assert property (
        @(posedge clk) !rst_n |-> !trap_valid_i
    ) else begin
        $error("trap_valid_o high during reset");
        fail_count++;
    end

    // mtvec and mepc are both word aligned
    target_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) trap_target_i[1:0] == 2'b00
    ) else begin
        $error("trap_target_o not word aligned");
        fail_count++;
    end

endmodule

bind trap_unit trap_unit_asserts i_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .cyc_i         (wb_cyc_i),
    .stb_i         (wb_stb_i),
    .ack_i         (wb_ack_o),
    .trap_valid_i  (trap_valid_o),
    .trap_target_i (trap_target_o)
);

// File: verification/trap_unit_tb.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module trap_unit_tb
    import csr_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int N_RAND = 150;
    localparam int N_STALL = 20;
    // read-backs, ecall and mret rounds, bus accesses and the interrupt wait
    localparam int N_OPS = N_RAND + N_STALL + 250;
    localparam int CYCLE_LIMIT = 20 * N_OPS + RESET_CYCLES;
    localparam xlen_t MSTATUS_WMASK = 64'h88;
    localparam instr_t INSTR_ECALL = 32'h0000_0073;
    localparam instr_t INSTR_MRET = 32'h3020_0073;

    logic    clk;
    logic    rst_n;
    logic    stall_n_i;
    xlen_t   pc_i;
    instr_t  instr_i;
    xlen_t   csr_wr_data_i;
    xlen_t   csr_rdata_o;
    logic    trap_valid_o;
    xlen_t   trap_target_o;
    logic    wb_cyc_i;
    logic    wb_stb_i;
    logic    wb_we_i;
    wb_adr_t wb_adr_i;
    xlen_t   wb_dat_i;
    xlen_t   wb_dat_o;
    logic    wb_ack_o;

    integer seed = 38;
    int     err_count = 0;
    int     check_count = 0;
    int     cycles = 0;
    int     start_errs;
    logic   irq_seen;

    // reference copies of the machine CSRs and the timer
    xlen_t m_mepc;
    xlen_t m_mtvec;
    xlen_t m_mstatus;
    xlen_t m_mcause;
    xlen_t m_mie;
    xlen_t m_mscratch;
    xlen_t m_mtime;
    xlen_t m_mtimecmp;

    csr_addr_t known_addrs [7] = '{`CSR_ADDR_MEPC, `CSR_ADDR_MTVEC, `CSR_ADDR_MSTATUS,
        `CSR_ADDR_MCAUSE, `CSR_ADDR_MIE, `CSR_ADDR_MIP, `CSR_ADDR_MSCRATCH};

    trap_unit i_dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // mtime runs on every edge out of reset
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_mtime <= '0;
        end else begin
            m_mtime <= m_mtime + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic model_mtip();
        return m_mtime >= m_mtimecmp;
    endfunction

    function automatic xlen_t model_read(input csr_addr_t addr);
        case (addr)
            `CSR_ADDR_MEPC:     return m_mepc;
            `CSR_ADDR_MTVEC:    return m_mtvec;
            `CSR_ADDR_MSTATUS:  return m_mstatus;
            `CSR_ADDR_MCAUSE:   return m_mcause;
            `CSR_ADDR_MIE:      return m_mie;
            `CSR_ADDR_MIP:      return xlen_t'(model_mtip()) << `IRQ_MTI;
            `CSR_ADDR_MSCRATCH: return m_mscratch;
            default:            return '0;
        endcase
    endfunction

    function automatic void model_write(input csr_addr_t addr, input xlen_t val);
        case (addr)
            `CSR_ADDR_MEPC:     m_mepc = val & ~xlen_t'(3);
            `CSR_ADDR_MTVEC:    m_mtvec = val & ~xlen_t'(3);
            `CSR_ADDR_MSTATUS:  m_mstatus = (m_mstatus & ~MSTATUS_WMASK) | (val & MSTATUS_WMASK);
            `CSR_ADDR_MCAUSE:   m_mcause = val;
            `CSR_ADDR_MIE:      m_mie = val;
            `CSR_ADDR_MSCRATCH: m_mscratch = val;
            // mip is read only and unknown addresses hold nothing
            default: begin
            end
        endcase
    endfunction

    function automatic instr_t csr_instr(input logic [2:0] f3, input csr_addr_t addr);
        return {addr, 5'd5, f3, 5'd10, `OPC_SYSTEM};
    endfunction

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // rw, rs or rc in register or immediate form
    function automatic logic [2:0] rand_f3();
        logic [1:0] op;
        op = 2'($unsigned($random(seed)) % 3) + 2'd1;
        return {1'($random(seed)), op};
    endfunction

    // mostly implemented CSRs and now and then any address
    function automatic csr_addr_t rand_addr();
        int r;
        r = $unsigned($random(seed)) % 8;
        if (r == 7) begin
            return csr_addr_t'($random(seed));
        end
        return known_addrs[r];
    endfunction

    task automatic check_csr_rdata(input xlen_t got, input xlen_t exp, input csr_addr_t addr);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: csr %h read %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_trap(input logic got_v, input xlen_t got_t,
                              input logic exp_v, input xlen_t exp_t);
        check_count++;
        if (got_v !== exp_v || (exp_v && got_t !== exp_t)) begin
            err_count++;
            $display("** Error at %0t: trap valid %b target %h, expected valid %b target %h",
                     $time, got_v, got_t, exp_v, exp_t);
        end
    endtask

    task automatic check_wb_data(input xlen_t got, input xlen_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: timer bus read %h, expected %h", $time, got, exp);
        end
    endtask

    // one instruction for one cycle is checked and then applied to the model
    task automatic do_instr(input instr_t instr, input xlen_t opnd, input xlen_t pc,
                            input logic stall_n);
        csr_addr_t addr;
        logic      is_csr;
        logic      irq;
        logic      enter;
        xlen_t     old_val;
        xlen_t     new_val;
        addr = instr[31:20];
        is_csr = (instr[6:0] == `OPC_SYSTEM) && (instr[13:12] != 2'b00);
        @(negedge clk);
        stall_n_i = stall_n;
        instr_i = instr;
        csr_wr_data_i = opnd;
        pc_i = pc;
        #10;
        irq = model_mtip() && m_mie[`IRQ_MTI] && m_mstatus[`MSTATUS_MIE];
        enter = irq || (instr == INSTR_ECALL);
        old_val = model_read(addr);
        if (is_csr) begin
            check_csr_rdata(csr_rdata_o, old_val, addr);
        end
        check_trap(trap_valid_o, trap_target_o, enter || (instr == INSTR_MRET),
                   enter ? m_mtvec : m_mepc);
        case (instr[13:12])
            2'b01:   new_val = opnd;
            2'b10:   new_val = old_val | opnd;
            default: new_val = old_val & ~opnd;
        endcase
        @(posedge clk);
        if (stall_n) begin
            irq_seen = irq_seen || irq;
            if (enter) begin
                m_mepc = pc & ~xlen_t'(3);
                m_mcause = irq ? `CAUSE_M_TIMER : `CAUSE_ECALL_M;
                m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
                m_mstatus[`MSTATUS_MIE] = 1'b0;
            end else if (instr == INSTR_MRET) begin
                m_mstatus[`MSTATUS_MIE] = m_mstatus[`MSTATUS_MPIE];
                m_mstatus[`MSTATUS_MPIE] = 1'b1;
            end else if (is_csr) begin
                model_write(addr, new_val);
            end
        end
    endtask

    // csrrs with a zero operand reads without a change
    task automatic read_all();
        for (int i = 0; i < 7; i++) begin
            do_instr(csr_instr(`F3_CSRRS, known_addrs[i]), '0, '0, 1'b1);
        end
    endtask

    // pipeline is stalled with a nop while the bus is busy
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input xlen_t dat);
        xlen_t exp;
        int    waited;
        @(negedge clk);
        stall_n_i = 1'b0;
        instr_i = '0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        case (adr)
            `TMR_OFS_MTIME:    exp = m_mtime;
            `TMR_OFS_MTIMECMP: exp = m_mtimecmp;
            default:           exp = '0;
        endcase
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack_o && waited < 8);
        if (!wb_ack_o) begin
            err_count++;
            $display("timer bus access at offset %h got no ack within 8 cycles", adr);
        end else if (we) begin
            if (adr == `TMR_OFS_MTIMECMP) begin
                m_mtimecmp = dat;
            end
        end else begin
            check_wb_data(wb_dat_o, exp);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int first_err);
        if (err_count == first_err) begin
            $display("test %-8s ok", name);
        end else begin
            $display("test %-8s %0d errors", name, err_count - first_err);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        stall_n_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        csr_wr_data_i = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        m_mepc = '0;
        m_mtvec = '0;
        m_mstatus = `MSTATUS_RESET;
        m_mcause = '0;
        m_mie = '0;
        m_mscratch = '0;
        m_mtimecmp = '1;
        irq_seen = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_errs = err_count;
        for (int i = 0; i < N_RAND; i++) begin
            do_instr(csr_instr(rand_f3(), rand_addr()), rand_word(), rand_word(),
                     ($random(seed) & 3) != 0);
        end
        read_all();
        report_test("random", start_errs);

        start_errs = err_count;
        for (int i = 0; i < N_STALL; i++) begin
            do_instr(csr_instr(rand_f3(), rand_addr()), rand_word(), rand_word(), 1'b0);
        end
        do_instr(INSTR_ECALL, '0, rand_word(), 1'b0);
        read_all();
        report_test("stall", start_errs);

        start_errs = err_count;
        for (int i = 0; i < 4; i++) begin
            do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MTVEC), rand_word(), '0, 1'b1);
            do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MSTATUS), rand_word(), '0, 1'b1);
            do_instr(INSTR_ECALL, rand_word(), rand_word(), 1'b1);
            read_all();
        end
        report_test("ecall", start_errs);

        start_errs = err_count;
        for (int i = 0; i < 4; i++) begin
            do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MEPC), rand_word(), '0, 1'b1);
            do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MSTATUS), rand_word(), '0, 1'b1);
            do_instr(INSTR_MRET, '0, rand_word(), 1'b1);
            read_all();
        end
        report_test("mret", start_errs);

        start_errs = err_count;
        bus_cycle(1'b0, `TMR_OFS_MTIME, '0);
        bus_cycle(1'b0, `TMR_OFS_MTIMECMP, '0);
        do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MTVEC), rand_word(), '0, 1'b1);
        do_instr(csr_instr(`F3_CSRRSI, `CSR_ADDR_MIE), xlen_t'(1) << `IRQ_MTI, '0, 1'b1);
        do_instr(csr_instr(`F3_CSRRS, `CSR_ADDR_MSTATUS), xlen_t'(1) << `MSTATUS_MIE, '0, 1'b1);
        bus_cycle(1'b1, `TMR_OFS_MTIMECMP, m_mtime + 40);
        bus_cycle(1'b0, `TMR_OFS_MTIMECMP, '0);
        bus_cycle(1'b0, `TMR_OFS_MTIME, '0);
        // mscratch writes race the interrupt and the one in the trap cycle is dropped
        irq_seen = 1'b0;
        for (int i = 0; i < 80 && !irq_seen; i++) begin
            do_instr(csr_instr(`F3_CSRRW, `CSR_ADDR_MSCRATCH), rand_word(), rand_word(), 1'b1);
        end
        if (!irq_seen) begin
            err_count++;
            $display("timer interrupt was never taken");
        end
        read_all();
        bus_cycle(1'b1, `TMR_OFS_MTIMECMP, '1);
        read_all();
        report_test("timer", start_errs);

        start_errs = err_count;
        for (int i = 0; i < 8; i++) begin
            do_instr(csr_instr(rand_f3(), 12'h7c0 + csr_addr_t'(i)), rand_word(), '0, 1'b1);
        end
        bus_cycle(1'b1, 4'h4, rand_word());
        bus_cycle(1'b0, 4'h4, '0);
        bus_cycle(1'b0, 4'hc, '0);
        bus_cycle(1'b0, `TMR_OFS_MTIMECMP, '0);
        read_all();
        report_test("unknown", start_errs);

        err_count += i_dut.i_asserts.fail_count;
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_if.sv
verilog/csr_decode.sv
verilog/csr_regfile.sv
verilog/clint_timer.sv
verilog/trap_unit.sv
verification/trap_unit_asserts.sv
verification/trap_unit_tb.sv

// File: verilog/clint_timer.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module clint_timer
    import csr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  xlen_t   wb_dat_i,
    output xlen_t   wb_dat_o,
    output logic    wb_ack_o,
    output logic    timer_irq_o
);

    xlen_t mtime;
    xlen_t mtimecmp;

    logic  req;
    logic  wr_mtime;
    logic  wr_mtimecmp;

    // new request only when ack is low, so acks never run back to back
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    assign wr_mtime = req && wb_we_i && (wb_adr_i == `TMR_OFS_MTIME);
    assign wr_mtimecmp = req && wb_we_i && (wb_adr_i == `TMR_OFS_MTIMECMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // free running counter, a bus write replaces the increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_mtime) begin
            mtime <= wb_dat_i;
        end else begin
            mtime <= mtime + xlen_t'(1);
        end
    end

    // all ones keeps the interrupt quiet after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp <= wb_dat_i;
        end
    end

    // read data is launched with ack
    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            case (wb_adr_i)
                `TMR_OFS_MTIME:    wb_dat_o <= mtime;
                `TMR_OFS_MTIMECMP: wb_dat_o <= mtimecmp;
                default:           wb_dat_o <= '0;
            endcase
        end
    end

    // level, stays high until mtimecmp moves past mtime
    assign timer_irq_o = (mtime >= mtimecmp);

endmodule

// File: verilog/csr_decode.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_decode
    import csr_pkg::*;
(
    input  instr_t instr_i,
    input  xlen_t  csr_wr_data_i,
    csr_if.decoder csr
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    csr_addr_t   addr;
    logic        is_system;
    logic        is_csr;
    xlen_t       new_val;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign addr   = instr_i[31:20];

    assign is_system = (opcode == `OPC_SYSTEM);
    assign is_csr    = is_system && (funct3[1:0] != 2'b00);

    always_comb begin
        if (!is_csr) begin
            csr.sel = CSR_NONE;
        end else begin
            case (addr)
                `CSR_ADDR_MEPC:     csr.sel = CSR_MEPC;
                `CSR_ADDR_MTVEC:    csr.sel = CSR_MTVEC;
                `CSR_ADDR_MSTATUS:  csr.sel = CSR_MSTATUS;
                `CSR_ADDR_MCAUSE:   csr.sel = CSR_MCAUSE;
                `CSR_ADDR_MIE:      csr.sel = CSR_MIE;
                `CSR_ADDR_MIP:      csr.sel = CSR_MIP;
                `CSR_ADDR_MSCRATCH: csr.sel = CSR_MSCRATCH;
                default:            csr.sel = CSR_NONE;
            endcase
        end
    end

    // operand holds rs1 or the zero extended immediate from the pipeline
    always_comb begin
        case (funct3[1:0])
            2'b01:   new_val = csr_wr_data_i;
            2'b10:   new_val = csr.rdata | csr_wr_data_i;
            default: new_val = csr.rdata & ~csr_wr_data_i;
        endcase
    end

    assign csr.wdata = new_val;
    assign csr.wr_en = is_csr;
    assign csr.ecall = (instr_i == {`F12_ECALL, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM});
    assign csr.mret  = (instr_i == {`F12_MRET, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM});

endmodule

// File: verilog/csr_if.sv
`timescale 1ns/10ps

interface csr_if
    import csr_pkg::*;
();

    // request side, decoded from the instruction word
    csr_sel_e sel;
    logic     wr_en;
    xlen_t    wdata;
    logic     ecall;
    logic     mret;

    // response side, current value of the selected CSR
    xlen_t    rdata;

    modport decoder (
        output sel,
        output wr_en,
        output wdata,
        output ecall,
        output mret,
        input  rdata
    );

    modport regfile (
        input  sel,
        input  wr_en,
        input  wdata,
        input  ecall,
        input  mret,
        output rdata
    );

endinterface

// File: verilog/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN            64

// machine CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// funct3 of the SYSTEM opcode
`define F3_CSRRW            3'b001
`define F3_CSRRS            3'b010
`define F3_CSRRC            3'b011
`define F3_CSRRWI           3'b101
`define F3_CSRRSI           3'b110
`define F3_CSRRCI           3'b111

`define OPC_SYSTEM          7'b1110011
// funct12 for the privileged forms (funct3 = 0)
`define F12_ECALL           12'h000
`define F12_MRET            12'h302

// mpp = 11, mie = mpie = 0
`define MSTATUS_RESET       64'h0000_0000_0000_1800
`define MSTATUS_MIE         3
`define MSTATUS_MPIE        7
// machine timer bit, same position in mie and mip
`define IRQ_MTI             7

`define CAUSE_ECALL_M       64'd11
`define CAUSE_M_TIMER       64'h8000_0000_0000_0007

`define TMR_OFS_MTIME       4'h0
`define TMR_OFS_MTIMECMP    4'h8

`endif

// File: verilog/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

    // one machine word
    typedef logic [`CSR_XLEN-1:0] xlen_t;

    typedef logic [31:0] instr_t;

    typedef logic [11:0] csr_addr_t;

    // byte address on the timer bus
    typedef logic [3:0] wb_adr_t;

    // implemented CSRs, CSR_NONE for anything else
    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_MEPC,
        CSR_MTVEC,
        CSR_MSTATUS,
        CSR_MCAUSE,
        CSR_MIE,
        CSR_MIP,
        CSR_MSCRATCH
    } csr_sel_e;

    // read-modify-write flavour, immediate forms share the same code
    typedef enum logic [1:0] {
        OP_RW,
        OP_RS,
        OP_RC
    } csr_op_e;

endpackage

// File: verilog/csr_regfile.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_n_i,
    input  xlen_t  pc_i,
    input  logic   timer_irq_i,
    csr_if.regfile csr,
    output logic   trap_valid_o,
    output xlen_t  trap_target_o
);

    // mtvec and mepc are word aligned
    localparam xlen_t ALIGN_MASK = ~xlen_t'(3);
    // only mie and mpie are writable in mstatus
    localparam xlen_t MSTATUS_WMASK = (xlen_t'(1) << `MSTATUS_MIE) |
                                      (xlen_t'(1) << `MSTATUS_MPIE);

    xlen_t mepc;
    xlen_t mtvec;
    xlen_t mstatus;
    xlen_t mcause;
    xlen_t mie;
    xlen_t mscratch;
    xlen_t mip;

    logic  irq_take;
    logic  trap_enter;

    // mip holds no state of its own, mtip follows the timer level
    always_comb begin
        mip = '0;
        mip[`IRQ_MTI] = timer_irq_i;
    end

    assign irq_take = mip[`IRQ_MTI] && mie[`IRQ_MTI] && mstatus[`MSTATUS_MIE];

    // interrupt wins over whatever instruction is presented
    assign trap_enter = irq_take || csr.ecall;

    assign trap_valid_o = trap_enter || csr.mret;
    assign trap_target_o = trap_enter ? mtvec : mepc;

    // combinational read port
    always_comb begin
        case (csr.sel)
            CSR_MEPC:     csr.rdata = mepc;
            CSR_MTVEC:    csr.rdata = mtvec;
            CSR_MSTATUS:  csr.rdata = mstatus;
            CSR_MCAUSE:   csr.rdata = mcause;
            CSR_MIE:      csr.rdata = mie;
            CSR_MIP:      csr.rdata = mip;
            CSR_MSCRATCH: csr.rdata = mscratch;
            default:      csr.rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc     <= '0;
            mtvec    <= '0;
            mstatus  <= `MSTATUS_RESET;
            mcause   <= '0;
            mie      <= '0;
            mscratch <= '0;
        end else if (stall_n_i) begin
            if (trap_enter) begin
                // trap entry, the pending csr write is dropped
                mepc <= pc_i & ALIGN_MASK;
                mcause <= irq_take ? `CAUSE_M_TIMER : `CAUSE_ECALL_M;
                mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
                mstatus[`MSTATUS_MIE] <= 1'b0;
            end else if (csr.mret) begin
                mstatus[`MSTATUS_MIE] <= mstatus[`MSTATUS_MPIE];
                mstatus[`MSTATUS_MPIE] <= 1'b1;
            end else if (csr.wr_en) begin
                case (csr.sel)
                    CSR_MEPC: begin
                        mepc <= csr.wdata & ALIGN_MASK;
                    end
                    CSR_MTVEC: begin
                        // direct mode only
                        mtvec <= csr.wdata & ALIGN_MASK;
                    end
                    CSR_MSTATUS: begin
                        mstatus <= (mstatus & ~MSTATUS_WMASK) |
                                   (csr.wdata & MSTATUS_WMASK);
                    end
                    CSR_MCAUSE: begin
                        mcause <= csr.wdata;
                    end
                    CSR_MIE: begin
                        mie <= csr.wdata;
                    end
                    CSR_MSCRATCH: begin
                        mscratch <= csr.wdata;
                    end
                    // mip is read only, none carries no write
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/trap_unit.sv
`timescale 1ns/10ps

module trap_unit
    import csr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall_n_i,
    input  xlen_t   pc_i,
    input  instr_t  instr_i,
    input  xlen_t   csr_wr_data_i,
    output xlen_t   csr_rdata_o,
    output logic    trap_valid_o,
    output xlen_t   trap_target_o,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  xlen_t   wb_dat_i,
    output xlen_t   wb_dat_o,
    output logic    wb_ack_o
);

    logic timer_irq;

    csr_if i_csr_if ();

    csr_decode i_csr_decode (
        .instr_i       (instr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .csr           (i_csr_if.decoder)
    );

    csr_regfile i_csr_regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .pc_i          (pc_i),
        .timer_irq_i   (timer_irq),
        .csr           (i_csr_if.regfile),
        .trap_valid_o  (trap_valid_o),
        .trap_target_o (trap_target_o)
    );

    clint_timer i_clint_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .timer_irq_o (timer_irq)
    );

    assign csr_rdata_o = i_csr_if.rdata;

endmodule
